/* src.f */
src/mem_geom_pkg.sv
src/ecc_pkg.sv
src/ecc_encode.sv
src/ecc_decode.sv
src/wr_align.sv
src/sram_1r1w.sv
src/rd_align.sv
src/align_ecc_top.sv
testbench/tb_align_ecc.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal -j 0
TOP      = tb_align_ecc
FILELIST = src.f
PASS_MSG = all tests passed

OBJ_DIR  = obj_dir

.PHONY: sim clean

# Build and run; status comes from the pass line in the output
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* testbench/tb_align_ecc.sv */
`timescale 1ns/1ps

module tb_align_ecc
  import mem_geom_pkg::*, ecc_pkg::*;
();

  localparam int SRAM_DELAY = 2;
  localparam int DRAIN_MAX  = 50;       // Cycles allowed for outstanding reads

  typedef struct packed {
    data_t       data;
    ecc_status_e status;
    padr_t       padr;
    int          smp_edge;              // Edge at which the DUT samples the read
  } expect_t;

  logic    clk;
  logic    rst;
  wr_req_t wr_req;
  rd_req_t rd_req;
  rd_rsp_t rd_rsp;

  int      seed = 32'h82ba_82f5;
  int      cyc = 0;
  data_t   shadow_data [1024];
  cw_t     shadow_flip [1024];
  expect_t exp_q [$];

  align_ecc_top #(
    .SRAM_DELAY (SRAM_DELAY)
  ) align_ecc_top_i (
    .clk    (clk),
    .rst    (rst),
    .wr_req (wr_req),
    .rd_req (rd_req),
    .rd_rsp (rd_rsp)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;                     // Equals the edge count after each edge
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Expected response and checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic expect_t expected_rsp(addr_t a);
    expect_t e;
    int      nflip;
    nflip      = $countones(shadow_flip[a]);
    e.data     = shadow_data[a];
    e.padr     = {a[1:0], a[9:2]};      // Lane above row
    e.smp_edge = 0;
    if (nflip == 0) begin
      e.status = ECC_OK;
    end else if (nflip == 1) begin
      e.status = ECC_CORR;
    end else begin
      e.status = ECC_UNCORR;
    end
    return e;
  endfunction

  task automatic stop_run(string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check(string name, logic [63:0] got, logic [63:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  always @(negedge clk) begin : compare_rsp
    expect_t e;
    if (!rst && rd_rsp.vld === 1'b1) begin
      if (exp_q.size() == 0) begin
        stop_run("read response arrived with no read outstanding");
      end else begin
        e = exp_q.pop_front();
        check("rd_rsp.status", rd_rsp.status, e.status);
        if (e.status != ECC_UNCORR) begin
          check("rd_rsp.data", rd_rsp.data, e.data);
        end
        check("rd_rsp.padr", rd_rsp.padr, e.padr);
        check("read latency", cyc - e.smp_edge, SRAM_DELAY + 1);
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  task automatic drive(logic wr_en, addr_t wa, data_t wd, cw_t wf, logic rd_en, addr_t ra);
    expect_t e;
    @(posedge clk);
    wr_req <= '{en: wr_en, addr: wa, data: wd, flip: wf};
    rd_req <= '{en: rd_en, addr: ra};
    // Expectation taken before this cycle's write
    if (rd_en) begin
      e          = expected_rsp(ra);
      e.smp_edge = cyc + 2;
      exp_q.push_back(e);
    end
    if (wr_en) begin
      shadow_data[wa] = wd;
      shadow_flip[wa] = wf;
    end
  endtask

  task automatic write_word(addr_t a, data_t d, cw_t f);
    drive(1'b1, a, d, f, 1'b0, '0);
  endtask

  task automatic read_word(addr_t a);
    drive(1'b0, '0, '0, '0, 1'b1, a);
  endtask

  task automatic idle(int n);
    for (int i = 0; i < n; i++) begin
      drive(1'b0, '0, '0, '0, 1'b0, '0);
    end
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while (exp_q.size() != 0) begin
      if (n >= DRAIN_MAX) begin
        stop_run("timeout while waiting for read responses");
      end else begin
        @(posedge clk);
        n++;
      end
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin : main
    addr_t a;
    addr_t base;
    addr_t list [16];
    int    p1;
    int    p2;
    clk    = 1'b0;
    rst    = 1'b1;
    wr_req = '0;
    rd_req = '0;
    for (int i = 0; i < 5; i++) begin
      @(posedge clk);
    end
    rst <= 1'b0;

    // Full write then readback
    for (int i = 0; i < 1024; i++) begin
      write_word(addr_t'(i), rand_word(), '0);
    end
    idle(2);                            // Write reaches the array
    for (int i = 0; i < 1024; i++) begin
      read_word(addr_t'(i));
    end
    idle(1);
    wait_drained();
    $display("readback of all addresses done");

    // Lane isolation in one row
    base = {row_t'(rand_word() % NUM_ROWS), 2'b00};
    for (int l = 0; l < NUM_WRDS; l++) begin
      write_word(base + addr_t'(l), rand_word(), '0);
    end
    write_word(base + addr_t'(rand_word() % NUM_WRDS), rand_word(), '0);
    idle(2);
    for (int l = 0; l < NUM_WRDS; l++) begin
      read_word(base + addr_t'(l));
    end
    idle(1);
    wait_drained();

    // Single-bit injection starting on the overall parity bit
    for (int i = 0; i < 16; i++) begin
      list[i] = addr_t'(rand_word());
      p1      = (i == 0) ? 0 : int'(rand_word() % CW_W);
      write_word(list[i], rand_word(), cw_t'(1) << p1);
    end
    idle(2);
    for (int i = 0; i < 16; i++) begin
      read_word(list[i]);
    end
    idle(1);
    wait_drained();

    // Double-bit injection at two distinct positions
    for (int i = 0; i < 16; i++) begin
      list[i] = addr_t'(rand_word());
      p1      = int'(rand_word() % CW_W);
      p2      = (p1 + 1 + int'(rand_word() % (CW_W - 1))) % CW_W;
      write_word(list[i], rand_word(), (cw_t'(1) << p1) | (cw_t'(1) << p2));
    end
    idle(2);
    for (int i = 0; i < 16; i++) begin
      read_word(list[i]);
    end
    idle(1);
    wait_drained();
    $display("error injection done");

    // Back-to-back reads in the low half and writes in the high half
    for (int i = 0; i < 200; i++) begin
      a = addr_t'(rand_word());
      a[BIT_ADDR-1] = 1'b1;
      drive(1'(rand_word()), a, rand_word(), '0, 1'b1, addr_t'(rand_word() % 512));
    end
    idle(1);
    wait_drained();
    $display("pipelined reads done");

    $display("all tests passed");
    $finish;
  end

endmodule

/* src/align_ecc_top.sv */
`timescale 1ns/1ps

module align_ecc_top import mem_geom_pkg::*, ecc_pkg::*; #(
  parameter int SRAM_DELAY = 2        // SRAM read latency, 1 to 4
) (
  input  logic    clk,
  input  logic    rst,
  input  wr_req_t wr_req,
  input  rd_req_t rd_req,
  output rd_rsp_t rd_rsp
);

  sram_wr_t  sram_wr;
  logic      rd_en;
  row_t      rd_row;
  row_data_t rd_data;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Write path, row memory, read path
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  wr_align wr_align_i (
    .clk     (clk),
    .rst     (rst),
    .wr_req  (wr_req),
    .sram_wr (sram_wr)
  );

  sram_1r1w #(
    .SRAM_DELAY (SRAM_DELAY)
  ) sram_1r1w_i (
    .clk     (clk),
    .rst     (rst),
    .sram_wr (sram_wr),
    .rd_en   (rd_en),
    .rd_row  (rd_row),
    .rd_data (rd_data)
  );

  rd_align #(
    .SRAM_DELAY (SRAM_DELAY)
  ) rd_align_i (
    .clk     (clk),
    .rst     (rst),
    .rd_req  (rd_req),
    .rd_en   (rd_en),
    .rd_row  (rd_row),
    .rd_data (rd_data),
    .rd_rsp  (rd_rsp)
  );

endmodule

/* src/rd_align.sv */
`timescale 1ns/1ps

module rd_align import mem_geom_pkg::*, ecc_pkg::*; #(
  parameter int SRAM_DELAY = 2
) (
  input  logic      clk,
  input  logic      rst,
  input  rd_req_t   rd_req,
  output logic      rd_en,
  output row_t      rd_row,
  input  row_data_t rd_data,
  output rd_rsp_t   rd_rsp
);

  typedef struct packed {
    logic  vld;
    padr_t padr;
  } trk_t;

  trk_t        trk [SRAM_DELAY+1];   // Matches the SRAM read stages
  trk_t        trk_out;
  cw_t         cw_sel;
  data_t       dec_data;
  ecc_status_e dec_status;

  // Issue straight to the SRAM so the array is read on the request edge
  assign rd_en  = rd_req.en;
  assign rd_row = addr_row(rd_req.addr);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Lane and row tracking through the SRAM latency
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    trk[0].padr <= '{lane: addr_lane(rd_req.addr), row: rd_row};
    for (int k = 1; k <= SRAM_DELAY; k++) begin
      trk[k].padr <= trk[k-1].padr;
    end
    if (rst) begin
      for (int k = 0; k <= SRAM_DELAY; k++) begin
        trk[k].vld <= 1'b0;
      end
    end else begin
      trk[0].vld <= rd_req.en;
      for (int k = 1; k <= SRAM_DELAY; k++) begin
        trk[k].vld <= trk[k-1].vld;
      end
    end
  end

  assign trk_out = trk[SRAM_DELAY];
  assign cw_sel  = rd_data[trk_out.padr.lane*CW_W +: CW_W];

  ecc_decode ecc_decode_i (
    .cw     (cw_sel),
    .data   (dec_data),
    .status (dec_status)
  );

  // Response register
  always_ff @(posedge clk) begin
    if (trk_out.vld) begin
      rd_rsp.data   <= dec_data;
      rd_rsp.status <= dec_status;
      rd_rsp.padr   <= trk_out.padr;  // Lane above row
    end
    if (rst) begin
      rd_rsp.vld <= 1'b0;
    end else begin
      rd_rsp.vld <= trk_out.vld;
    end
  end

endmodule

/* src/sram_1r1w.sv */
`timescale 1ns/1ps

module sram_1r1w import mem_geom_pkg::*, ecc_pkg::*; #(
  parameter int SRAM_DELAY = 2
) (
  input  logic      clk,
  input  logic      rst,
  input  sram_wr_t  sram_wr,
  input  logic      rd_en,
  input  row_t      rd_row,
  output row_data_t rd_data
);

  row_data_t             mem [NUM_ROWS];
  row_data_t             rd_pipe [SRAM_DELAY+1];
  logic [SRAM_DELAY-1:0] rd_vld;  // Stage holds a read in flight

  always_ff @(posedge clk) begin
    if (sram_wr.en) begin
      mem[sram_wr.row] <= (sram_wr.din & sram_wr.bw) | (mem[sram_wr.row] & ~sram_wr.bw);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Read port, array capture then SRAM_DELAY register stages
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_pipe[0] <= mem[rd_row];  // Old row on a same-edge write
    end
    for (int k = 1; k <= SRAM_DELAY; k++) begin
      if (rd_vld[k-1]) begin
        rd_pipe[k] <= rd_pipe[k-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_vld <= '0;
    end else begin
      rd_vld[0] <= rd_en;
      for (int k = 1; k < SRAM_DELAY; k++) begin
        rd_vld[k] <= rd_vld[k-1];
      end
    end
  end

  assign rd_data = rd_pipe[SRAM_DELAY];

endmodule

/* src/wr_align.sv */
`timescale 1ns/1ps

module wr_align import mem_geom_pkg::*, ecc_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  wr_req_t  wr_req,
  output sram_wr_t sram_wr
);

  row_t      row;
  lane_t     lane;
  cw_t       cw_enc;
  cw_t       cw_inj;
  row_data_t bw;

  assign row  = addr_row(wr_req.addr);
  assign lane = addr_lane(wr_req.addr);

  ecc_encode ecc_encode_i (
    .data (wr_req.data),
    .cw   (cw_enc)
  );

  assign cw_inj = cw_enc ^ wr_req.flip;  // Error injection

  // Bit enables for the addressed lane only
  always_comb begin
    bw = '0;
    for (int w = 0; w < NUM_WRDS; w++) begin
      if (lane == lane_t'(w)) begin
        bw[w*CW_W +: CW_W] = '1;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Registered SRAM write
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    sram_wr.row <= row;
    sram_wr.bw  <= bw;
    sram_wr.din <= {NUM_WRDS{cw_inj}};   // Lane picked by bw
    if (rst) begin
      sram_wr.en <= 1'b0;
    end else begin
      sram_wr.en <= wr_req.en;
    end
  end

endmodule

/* src/ecc_decode.sv */
`timescale 1ns/1ps

module ecc_decode import mem_geom_pkg::*, ecc_pkg::*; (
  input  cw_t         cw,
  output data_t       data,
  output ecc_status_e status
);

  syn_t syn;
  logic par;
  cw_t  fixed;

  assign syn = cw_syndrome(cw);
  assign par = ^cw;                     // Odd means an odd error count

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Classification and correction
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    fixed  = cw;
    status = ECC_OK;
    if (par) begin
      if (syn < CW_W) begin
        status     = ECC_CORR;
        fixed[syn] = ~cw[syn];          // Zero syndrome flips the parity bit
      end else begin
        // Points past the codeword, so at least three bits are bad
        status = ECC_UNCORR;
      end
    end else if (syn != '0) begin
      status = ECC_UNCORR;
    end
  end

  assign data = cw_extract(fixed);

endmodule

/* src/ecc_encode.sv */
`timescale 1ns/1ps

module ecc_encode import mem_geom_pkg::*, ecc_pkg::*; (
  input  data_t data,
  output cw_t   cw
);

  cw_t  placed;
  syn_t chk;

  assign placed = cw_place(data);
  assign chk    = cw_syndrome(placed);  // Check positions still zero

  // Writing the syndrome into the check positions cancels it
  always_comb begin
    cw = placed;
    for (int k = 0; k < SYN_W; k++) begin
      cw[1 << k] = chk[k];
    end
    cw[0] = ^cw[CW_W-1:1];              // Overall parity, even
  end

endmodule

/* src/ecc_pkg.sv */
package ecc_pkg;
  import mem_geom_pkg::*;

  localparam int ECC_W = 7;
  localparam int SYN_W = ECC_W - 1;               // Hamming part only
  localparam int CW_W  = DATA_W + ECC_W;

  typedef logic [CW_W-1:0]          cw_t;
  typedef logic [NUM_WRDS*CW_W-1:0] row_data_t;   // Lane 0 in the low bits
  typedef logic [SYN_W-1:0]         syn_t;

  typedef enum logic [1:0] {
    ECC_OK,
    ECC_CORR,
    ECC_UNCORR
  } ecc_status_e;

  typedef struct packed {
    logic  en;
    addr_t addr;
    data_t data;
    cw_t   flip;                                  // Bits inverted before storage
  } wr_req_t;

  typedef struct packed {
    logic  en;
    addr_t addr;
  } rd_req_t;

  typedef struct packed {
    logic        vld;
    data_t       data;
    ecc_status_e status;
    padr_t       padr;
  } rd_rsp_t;

  typedef struct packed {
    logic      en;
    row_t      row;
    row_data_t bw;
    row_data_t din;
  } sram_wr_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Codeword layout helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Data goes to every position above 0 that is not a power of two
  function automatic cw_t cw_place(data_t d);
    cw_t cw;
    int  j;
    cw = '0;
    j = 0;
    for (int p = 1; p < CW_W; p++) begin
      if ((p & (p - 1)) != 0) begin
        cw[p] = d[j];
        j++;
      end
    end
    return cw;
  endfunction

  function automatic data_t cw_extract(cw_t cw);
    data_t d;
    int    j;
    d = '0;
    j = 0;
    for (int p = 1; p < CW_W; p++) begin
      if ((p & (p - 1)) != 0) begin
        d[j] = cw[p];
        j++;
      end
    end
    return d;
  endfunction

  // XOR of the positions of all set bits, bit 0 excluded
  function automatic syn_t cw_syndrome(cw_t cw);
    syn_t s;
    s = '0;
    for (int p = 1; p < CW_W; p++) begin
      if (cw[p]) begin
        s ^= syn_t'(p);
      end
    end
    return s;
  endfunction

endpackage

/* src/mem_geom_pkg.sv */
package mem_geom_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Logical and physical geometry
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int DATA_W   = 32;
  localparam int NUM_WRDS = 4;                    // Words per row
  localparam int BIT_WRDS = 2;
  localparam int NUM_ROWS = 256;
  localparam int BIT_ROWS = 8;
  localparam int BIT_ADDR = BIT_ROWS + BIT_WRDS;  // Lane in the low bits

  typedef logic [BIT_ADDR-1:0] addr_t;
  typedef logic [BIT_ROWS-1:0] row_t;
  typedef logic [BIT_WRDS-1:0] lane_t;
  typedef logic [DATA_W-1:0]   data_t;

  typedef struct packed {
    lane_t lane;
    row_t  row;
  } padr_t;

  function automatic row_t addr_row(addr_t a);
    return a[BIT_ADDR-1:BIT_WRDS];
  endfunction

  function automatic lane_t addr_lane(addr_t a);
    return a[BIT_WRDS-1:0];
  endfunction

endpackage
